// ==== files.f ====
+incdir+rtl
rtl/lcdPkg.sv
rtl/lcdDelayTimer.sv
rtl/lcdNibbleWriter.sv
rtl/lcdSequencer.sv
rtl/lcdTop.sv
sim/tbLcdTop.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile and run the LCD controller testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal \
   -f files.f \
   --top-module tbLcdTop \
   -o simv

./obj_dir/simv | tee sim.log

if grep -q "\*\*\* FAILED \*\*\*" sim.log; then
   echo "Simulation failed, see sim.log"
   exit 1
fi

echo "Simulation finished without failures"
exit 0

// ==== sim/tbLcdTop.sv ====
`timescale 1ns/10ps
`include "lcd_consts.svh"

module tbLcdTop;

   // One expected LCD write
   typedef struct packed
   {
      logic           rs;
      lcdPkg::lcdByte data;
      logic           fullByte;    // Both nibbles on the bus
   } writeEntry;

   localparam int  writeCount  = 18;     // 4 wake-up, 4 commands, 10 characters
   localparam int  nibbleCount = 32;     // 4 wake-up + 2 x 14 bytes
   localparam int  quietCycles = 200;    // Window after done with no pulses
   localparam longint delaySum = `LCD_PWR_WAIT + `LCD_WAKE_WAIT1 + `LCD_WAKE_WAIT2
      + `LCD_CMD_WAIT + `LCD_CLR_WAIT + `LCD_SETUP + `LCD_ENB_WIDTH + `LCD_HOLD
      + `LCD_NIBBLE_GAP;
   localparam longint watchdogNs = 2 * delaySum * nibbleCount * 40 + 100000;

   logic           clk;
   logic           rstN;
   lcdPkg::lcdBus  lcd;
   logic           done;

   integer           seed;
   int               checkCount;
   int               errCount;
   int               testStart;          // errCount when a test began
   int               resetAt;            // Pulse count for mid-run reset
   int               cycle;              // Negedge sample count
   int               lastChange;         // Sample where rs or data last moved
   int               riseCycle;
   int               fallCycle;
   int               pulseCount;
   int               writeIdx;           // Next expected write
   logic             lowHalf;            // Waiting for low nibble
   lcdPkg::lcdNibble highNibble;
   lcdPkg::lcdBus    prevBus;
   logic             prevDone;

   lcdTop #(.clkPerTick(1)) lcdTop_i
   (
      .clk  (clk),
      .rstN (rstN),
      .lcd  (lcd),
      .done (done)
   );

   always #20 clk = ~clk;   // 40 ns period

   //////////////////////////////
   // Reference and compares
   //////////////////////////////

   // Expected rs, byte and nibble count of write number index
   function automatic writeEntry expectedWrite(input int index);
      string     msg;
      writeEntry w;
      msg        = "HOLA MUNDO";
      w.rs       = 1'b0;
      w.fullByte = 1'b1;
      w.data     = 8'h00;
      if (index < 4)
      begin
         w.fullByte = 1'b0;                            // Wake-up, high nibble only
         w.data     = (index == 3) ? 8'h20 : 8'h30;
      end
      else if (index < 8)
      begin
         case (index)
            4:       w.data = 8'h28;                   // Function set
            5:       w.data = 8'h06;                   // Entry mode
            6:       w.data = 8'h0C;                   // Display on
            default: w.data = 8'h01;                   // Clear
         endcase
      end
      else
      begin
         w.rs   = 1'b1;                                // Characters go to data register
         w.data = msg[index-8];
      end
      return w;
   endfunction

   task automatic reportError(input string msg);
      errCount++;
      $display("ERR %0t: %s", $time, msg);
   endtask

   task automatic checkNibble(input string what, input lcdPkg::lcdNibble got,
                              input lcdPkg::lcdNibble exp);
      checkCount++;
      if (got !== exp)
         reportError($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic checkByte(input string what, input lcdPkg::lcdByte got,
                            input lcdPkg::lcdByte exp);
      checkCount++;
      if (got !== exp)
         reportError($sformatf("%s got %h expected %h", what, got, exp));
   endtask

   task automatic checkRs(input string what, input logic got, input logic exp);
      checkCount++;
      if (got !== exp)
         reportError($sformatf("%s rs got %b expected %b", what, got, exp));
   endtask

   task automatic checkFlag(input string what, input logic got, input logic exp);
      checkCount++;
      if (got !== exp)
         reportError($sformatf("%s got %b expected %b", what, got, exp));
   endtask

   task automatic checkTicks(input string what, input lcdPkg::tickCount got,
                             input lcdPkg::tickCount exp);
      checkCount++;
      if (got !== exp)
         reportError($sformatf("%s got %0d expected %0d", what, got, exp));
   endtask

   // Pair nibbles into writes and compare with the reference
   task automatic recordNibble(input logic rs, input lcdPkg::lcdNibble data);
      writeEntry w;
      if (writeIdx >= writeCount)
         reportError($sformatf("enable pulse %0d after the last write", pulseCount));
      else
      begin
         w = expectedWrite(writeIdx);
         checkRs($sformatf("write %0d", writeIdx), rs, w.rs);
         if (!w.fullByte)
         begin
            checkNibble($sformatf("wake-up %0d", writeIdx), data, w.data[7:4]);
            writeIdx++;
         end
         else if (!lowHalf)
         begin
            highNibble = data;                         // Low nibble follows
            checkNibble($sformatf("write %0d high", writeIdx), data, w.data[7:4]);
            lowHalf = 1'b1;
         end
         else
         begin
            checkByte($sformatf("write %0d", writeIdx), {highNibble, data}, w.data);
            lowHalf = 1'b0;
            writeIdx++;
         end
      end
   endtask

   //////////////////////////////
   // Bus monitor
   //////////////////////////////

   // Sample mid-cycle, away from the rising edge
   always @(negedge clk)
   begin
      cycle++;
      if (!rstN)
      begin
         writeIdx   = 0;
         lowHalf    = 1'b0;
         pulseCount = 0;
         lastChange = cycle;
         riseCycle  = cycle;
         fallCycle  = cycle - 100;                     // No recent fall
      end
      else
      begin
         if ((lcd.rs !== prevBus.rs) || (lcd.data !== prevBus.data))
         begin
            if (lcd.e || prevBus.e)
               reportError("rs or data changed while e was high");
            else if (cycle - fallCycle < int'(`LCD_HOLD))
               reportError("rs or data changed inside the hold time");
            lastChange = cycle;
         end
         if (lcd.e && !prevBus.e)                      // Rising e
         begin
            if (cycle - lastChange < int'(`LCD_SETUP))
               reportError("e rose before the setup time");
            riseCycle = cycle;
         end
         if (!lcd.e && prevBus.e)                      // Falling e
         begin
            checkTicks("e width", lcdPkg::tickCount'(cycle - riseCycle), `LCD_ENB_WIDTH);
            fallCycle = cycle;
            pulseCount++;
            recordNibble(lcd.rs, lcd.data);
         end
         if (done && !prevDone && (writeIdx != writeCount))
            reportError($sformatf("done rose after only %0d writes", writeIdx));
      end
      prevBus  = lcd;
      prevDone = done;
   end

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   // Reset for 16 edges, bus checked in its last cycle
   task automatic applyReset();
      @(posedge clk);
      #2 rstN = 1'b0;
      repeat (15) @(posedge clk);
      @(negedge clk);
      checkFlag("reset e", lcd.e, 1'b0);
      checkRs("reset", lcd.rs, 1'b0);
      checkNibble("reset data", lcd.data, 4'h0);
      checkFlag("reset done", done, 1'b0);
      @(posedge clk);
      #2 rstN = 1'b1;
   endtask

   task automatic finishRun(input int testNum);
      wait (done);
      repeat (quietCycles) @(posedge clk);             // No pulse may follow
      if (pulseCount != nibbleCount)
         reportError($sformatf("test %0d saw %0d pulses", testNum, pulseCount));
   endtask

   task automatic reportTest(input int testNum, input string name);
      $display("Test %0d %s finished with %0d errors", testNum, name,
               errCount - testStart);
   endtask

   initial
   begin
      clk        = 1'b0;
      rstN       = 1'b0;
      seed       = 4892;
      checkCount = 0;
      errCount   = 0;
      cycle      = 0;
      prevBus    = '0;
      prevDone   = 1'b0;

      testStart = errCount;
      applyReset();
      reportTest(1, "reset values");

      testStart = errCount;
      finishRun(2);
      reportTest(2, "full sequence");

      // Restart, then reset again partway through
      testStart = errCount;
      resetAt   = 1 + int'($unsigned($random(seed)) % (nibbleCount - 1));
      applyReset();
      wait (pulseCount == resetAt);
      applyReset();
      finishRun(3);
      reportTest(3, $sformatf("reset after pulse %0d", resetAt));

      $display("Checks: %0d, errors: %0d", checkCount, errCount);
      if (errCount == 0)
         $display("*** PASSED ***");
      else
         $display("*** FAILED ***");
      $finish;
   end

   // Watchdog
   initial
   begin
      #(watchdogNs);
      $display("Timeout: done never rose within %0d ns", watchdogNs);
      $display("*** FAILED ***");
      $finish;
   end

endmodule

// ==== rtl/lcdTop.sv ====
`timescale 1ns/10ps

module lcdTop
#(
   parameter int clkPerTick = 50    // 50 cycles per tick
)
(
   input  logic          clk,
   input  logic          rstN,
   output lcdPkg::lcdBus lcd,
   output logic          done
);

   lcdPkg::lcdWriteReq req;        // Current step
   logic               reqValid;
   logic               reqReady;
   logic               delayLoad;
   lcdPkg::tickCount   delayLen;
   logic               delayDone;

   //////////////////////////////
   // Sequencer and writer
   //////////////////////////////

   lcdSequencer lcdSequencer_i
   (
      .clk      (clk),
      .rstN     (rstN),
      .req      (req),
      .reqValid (reqValid),
      .reqReady (reqReady),
      .done     (done)
   );

   lcdNibbleWriter lcdNibbleWriter_i
   (
      .clk       (clk),
      .rstN      (rstN),
      .req       (req),
      .reqValid  (reqValid),
      .reqReady  (reqReady),
      .lcd       (lcd),
      .delayLoad (delayLoad),
      .delayLen  (delayLen),
      .delayDone (delayDone)
   );

   // Shared by every phase of the writer
   lcdDelayTimer #(.clkPerTick(clkPerTick)) lcdDelayTimer_i
   (
      .clk       (clk),
      .rstN      (rstN),
      .delayLoad (delayLoad),
      .delayLen  (delayLen),
      .delayDone (delayDone)
   );

endmodule

// ==== rtl/lcdSequencer.sv ====
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcdSequencer
(
   input  logic               clk,
   input  logic               rstN,
   output lcdPkg::lcdWriteReq req,
   output logic               reqValid,
   input  logic               reqReady,
   output logic               done
);

   lcdPkg::seqState  state;
   lcdPkg::stepIndex step;     // Next step to issue

   // Build one table entry
   function automatic lcdPkg::lcdWriteReq makeReq
   (
      input logic             rs,
      input lcdPkg::lcdByte   data,
      input logic             fullByte,
      input lcdPkg::tickCount postWait
   );
      lcdPkg::lcdWriteReq r;
      r.rs       = rs;
      r.data     = data;
      r.fullByte = fullByte;
      r.postWait = postWait;
      return r;
   endfunction

   //////////////////////////////
   // Step table
   //////////////////////////////

   always_comb
   begin
      case (step)
         // Wake-up, high nibble only
         5'd0:  req = makeReq(1'b0, 8'h30, 1'b0, `LCD_WAKE_WAIT1);
         5'd1:  req = makeReq(1'b0, 8'h30, 1'b0, `LCD_WAKE_WAIT2);
         5'd2:  req = makeReq(1'b0, 8'h30, 1'b0, `LCD_CMD_WAIT);
         5'd3:  req = makeReq(1'b0, 8'h20, 1'b0, `LCD_CMD_WAIT);   // Switch to 4-bit
         // Configuration
         5'd4:  req = makeReq(1'b0, `LCD_CMD_FUNC, 1'b1, `LCD_CMD_WAIT);
         5'd5:  req = makeReq(1'b0, `LCD_CMD_ENTRY, 1'b1, `LCD_CMD_WAIT);
         5'd6:  req = makeReq(1'b0, `LCD_CMD_DISPLAY, 1'b1, `LCD_CMD_WAIT);
         5'd7:  req = makeReq(1'b0, `LCD_CMD_CLEAR, 1'b1, `LCD_CLR_WAIT);
         // Message, data register
         5'd8:  req = makeReq(1'b1, 8'h48, 1'b1, `LCD_CMD_WAIT);   // H
         5'd9:  req = makeReq(1'b1, 8'h4F, 1'b1, `LCD_CMD_WAIT);   // O
         5'd10: req = makeReq(1'b1, 8'h4C, 1'b1, `LCD_CMD_WAIT);   // L
         5'd11: req = makeReq(1'b1, 8'h41, 1'b1, `LCD_CMD_WAIT);   // A
         5'd12: req = makeReq(1'b1, 8'h20, 1'b1, `LCD_CMD_WAIT);   // Space
         5'd13: req = makeReq(1'b1, 8'h4D, 1'b1, `LCD_CMD_WAIT);   // M
         5'd14: req = makeReq(1'b1, 8'h55, 1'b1, `LCD_CMD_WAIT);   // U
         5'd15: req = makeReq(1'b1, 8'h4E, 1'b1, `LCD_CMD_WAIT);   // N
         5'd16: req = makeReq(1'b1, 8'h44, 1'b1, `LCD_CMD_WAIT);   // D
         5'd17: req = makeReq(1'b1, 8'h4F, 1'b1, `LCD_CMD_WAIT);   // O
         default:
            req = makeReq(1'b0, 8'h00, 1'b0, `LCD_CMD_WAIT);        // Past the end
      endcase
   end

   //////////////////////////////
   // Table walker FSM
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state <= lcdPkg::seqIdle;
         step  <= '0;
      end
      else
      begin
         case (state)
            lcdPkg::seqIdle:
               if (reqReady)                  // Power wait over
                  state <= lcdPkg::seqIssue;
            lcdPkg::seqIssue:
               if (reqReady)                  // Transfer on this edge
               begin
                  step  <= step + 1'b1;
                  state <= lcdPkg::seqWaitAccept;
               end
            lcdPkg::seqWaitAccept:
               if (reqReady)                  // Writer back in idle
               begin
                  if (step == `LCD_STEP_COUNT)
                     state <= lcdPkg::seqDone;
                  else
                     state <= lcdPkg::seqIssue;
               end
            lcdPkg::seqDone:
               state <= lcdPkg::seqDone;      // Stay until reset
            default:
               state <= lcdPkg::seqIdle;
         endcase
      end
   end

   assign reqValid = (state == lcdPkg::seqIssue);   // Req stable while step holds
   assign done     = (state == lcdPkg::seqDone);

endmodule

// ==== rtl/lcdNibbleWriter.sv ====
`timescale 1ns/10ps
`include "lcd_consts.svh"

module lcdNibbleWriter
(
   input  logic               clk,
   input  logic               rstN,
   input  lcdPkg::lcdWriteReq req,
   input  logic               reqValid,
   output logic               reqReady,
   output lcdPkg::lcdBus      lcd,
   output logic               delayLoad,
   output lcdPkg::tickCount   delayLen,
   input  logic               delayDone
);

   lcdPkg::writerState state;
   lcdPkg::writerState nextState;
   lcdPkg::lcdWriteReq reqQ;       // Request being written
   lcdPkg::lcdBus      busQ;       // Registered LCD pins
   logic               lowPhase;   // Low nibble on the bus
   logic               pwrArmed;   // Power wait already loaded
   logic               accept;     // Handshake this cycle

   assign reqReady = (state == lcdPkg::wrIdle);   // One request in flight
   assign accept   = reqReady && reqValid;
   assign lcd      = busQ;

   //////////////////////////////
   // Next state and timer load
   //////////////////////////////

   always_comb
   begin
      nextState = state;
      delayLoad = 1'b0;
      delayLen  = `LCD_SETUP;
      case (state)
         lcdPkg::wrIdle:
            if (reqValid)
            begin
               nextState = lcdPkg::wrSetup;   // High nibble first
               delayLoad = 1'b1;
               delayLen  = `LCD_SETUP;
            end
         lcdPkg::wrSetup:
            if (delayDone)
            begin
               nextState = lcdPkg::wrEnable;
               delayLoad = 1'b1;
               delayLen  = `LCD_ENB_WIDTH;
            end
         lcdPkg::wrEnable:
            if (delayDone)
            begin
               nextState = lcdPkg::wrHold;
               delayLoad = 1'b1;
               delayLen  = `LCD_HOLD;
            end
         lcdPkg::wrHold:
            if (delayDone)
            begin
               delayLoad = 1'b1;
               if (reqQ.fullByte && !lowPhase)   // Low nibble still to go
               begin
                  nextState = lcdPkg::wrGap;
                  delayLen  = `LCD_NIBBLE_GAP;
               end
               else
               begin
                  nextState = lcdPkg::wrPost;
                  delayLen  = reqQ.postWait;
               end
            end
         lcdPkg::wrGap:
            if (delayDone)
            begin
               nextState = lcdPkg::wrSetup;
               delayLoad = 1'b1;
               delayLen  = `LCD_SETUP;
            end
         lcdPkg::wrPost:
            if (!pwrArmed)
            begin
               // First cycle out of reset starts the power-up wait
               delayLoad = 1'b1;
               delayLen  = `LCD_PWR_WAIT;
            end
            else if (delayDone)
               nextState = lcdPkg::wrIdle;
         default:
            nextState = lcdPkg::wrIdle;
      endcase
   end

   //////////////////////////////
   // State and bus registers
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         state    <= lcdPkg::wrPost;   // Power wait, bus quiet
         busQ     <= '0;
         lowPhase <= 1'b0;
         pwrArmed <= 1'b0;
      end
      else
      begin
         state    <= nextState;
         pwrArmed <= 1'b1;
         busQ.e   <= (nextState == lcdPkg::wrEnable);   // e high only while enabled
         if (accept)
         begin
            busQ.rs   <= req.rs;
            busQ.data <= req.data[7:4];
            lowPhase  <= 1'b0;
         end
         else if ((state == lcdPkg::wrGap) && delayDone)
         begin
            busQ.data <= reqQ.data[3:0];   // Setup of low nibble begins
            lowPhase  <= 1'b1;
         end
      end
   end

   // Request payload
   always_ff @(posedge clk)
   begin
      if (accept)
         reqQ <= req;
   end

endmodule

// ==== rtl/lcdDelayTimer.sv ====
`timescale 1ns/10ps

module lcdDelayTimer
#(
   parameter int clkPerTick = 50    // Clock cycles per tick
)
(
   input  logic             clk,
   input  logic             rstN,
   input  logic             delayLoad,
   input  lcdPkg::tickCount delayLen,
   output logic             delayDone
);

   // Prescaler width, at least one bit
   localparam int presWidth = (clkPerTick > 1) ? $clog2(clkPerTick) : 1;
   localparam logic [presWidth-1:0] presTop = presWidth'(clkPerTick - 1);

   logic                   active;     // Delay running
   logic [presWidth-1:0]   presCount;  // Cycles left in this tick
   lcdPkg::tickCount       ticksLeft;

   //////////////////////////////
   // Prescaler and tick counter
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (!rstN)
      begin
         active    <= 1'b0;
         presCount <= '0;
         ticksLeft <= '0;
      end
      else if (delayLoad)                 // Load wins over counting
      begin
         active    <= 1'b1;
         presCount <= presTop;            // Prescaler restarts
         ticksLeft <= (delayLen == '0) ? 16'd1 : delayLen;  // Zero means one tick
      end
      else if (active)
      begin
         if (presCount == '0)             // End of a tick
         begin
            presCount <= presTop;
            ticksLeft <= ticksLeft - 16'd1;
            if (ticksLeft == 16'd1)
               active <= 1'b0;            // Last tick done
         end
         else
            presCount <= presCount - 1'b1;
      end
   end

   // One-cycle pulse in the last cycle of the last tick
   assign delayDone = active && (presCount == '0) && (ticksLeft == 16'd1);

endmodule

// ==== rtl/lcdPkg.sv ====
package lcdPkg;

   //////////////////////////////
   // Vector types
   //////////////////////////////

   typedef logic [3:0]  lcdNibble;  // One nibble on the bus
   typedef logic [7:0]  lcdByte;    // Command or character code
   typedef logic [15:0] tickCount;  // Delay length in ticks
   typedef logic [4:0]  stepIndex;  // Step table position

   //////////////////////////////
   // Structs
   //////////////////////////////

   // Write request from sequencer to nibble writer
   typedef struct packed
   {
      logic     rs;        // Register select
      lcdByte   data;
      logic     fullByte;  // Both nibbles, else high nibble only
      tickCount postWait;  // Wait after the last nibble
   } lcdWriteReq;

   // LCD pins in 4-bit mode
   typedef struct packed
   {
      logic     rs;
      logic     e;
      lcdNibble data;
   } lcdBus;

   //////////////////////////////
   // State machines
   //////////////////////////////

   typedef enum logic [1:0]
   {
      seqIdle,
      seqIssue,
      seqWaitAccept,
      seqDone
   } seqState;

   typedef enum logic [2:0]
   {
      wrIdle,
      wrSetup,
      wrEnable,
      wrHold,
      wrGap,
      wrPost
   } writerState;

endpackage

// ==== rtl/lcd_consts.svh ====
`ifndef LCD_CONSTS_SVH
`define LCD_CONSTS_SVH

//////////////////////////////
// Delays in ticks
//////////////////////////////

// Power-up wait before the first wake-up nibble
`define LCD_PWR_WAIT    16'd750

// Wait after the first wake-up nibble
`define LCD_WAKE_WAIT1  16'd205

// Wait after the second wake-up nibble
`define LCD_WAKE_WAIT2  16'd5

`define LCD_CMD_WAIT    16'd20     // Normal command and character wait
`define LCD_CLR_WAIT    16'd82     // Clear display is slow

//////////////////////////////
// Enable pulse shape
//////////////////////////////

`define LCD_SETUP       16'd2      // Data valid before e rises
`define LCD_ENB_WIDTH   16'd12     // Width of e high
`define LCD_HOLD        16'd1      // Data held after e falls
`define LCD_NIBBLE_GAP  16'd1      // Between high and low nibble

//////////////////////////////
// Step table
//////////////////////////////

// 4 wake-up nibbles, 4 commands, 10 characters
`define LCD_STEP_COUNT  5'd18

`define LCD_CMD_FUNC    8'h28      // 4-bit bus, 2 lines, 5x8 font
`define LCD_CMD_ENTRY   8'h06      // Increment, no shift
`define LCD_CMD_DISPLAY 8'h0C      // Display on, cursor off
`define LCD_CMD_CLEAR   8'h01      // Clear and home

`endif
